//--- hw/mem_pkg.sv
// memory stage types: request struct, data and address widths, access size codes
`default_nettype none

package mem_pkg;

  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;     // one data doubleword
  typedef logic [XLEN-1:0] addr_t;     // byte address
  typedef logic [2:0]      byte_off_t; // byte lane inside a doubleword
  typedef logic [7:0]      strb_t;     // one bit per byte lane

  // log2 of the byte count
  typedef logic [1:0] lsu_size_t;

  localparam lsu_size_t SIZE_BYTE  = 2'd0;
  localparam lsu_size_t SIZE_HALF  = 2'd1;
  localparam lsu_size_t SIZE_WORD  = 2'd2;
  localparam lsu_size_t SIZE_DWORD = 2'd3;

  // request from the pipeline
  typedef struct packed {
    addr_t     addr;
    xlen_t     wdata; // value in the low bytes
    lsu_size_t size;
    logic      sext;
    logic      rd_en;
    logic      wr_en;
  } lsu_req_t;

endpackage

`default_nettype wire

//--- hw/bus_pkg.sv
// data bus types: write request, read request and read response payloads
`default_nettype none

package bus_pkg;

  typedef struct packed {
    mem_pkg::addr_t addr;
    mem_pkg::xlen_t data; // already shifted to its byte lanes
    mem_pkg::strb_t strb;
  } wr_req_t;

  typedef struct packed {
    mem_pkg::addr_t     addr;
    mem_pkg::lsu_size_t size;
  } rd_req_t;

  // full doubleword, lane selection is done by the requester
  typedef struct packed {
    mem_pkg::xlen_t data;
  } rd_resp_t;

endpackage

`default_nettype wire

//--- hw/store_align.sv
// store alignment: moves store data and byte strobes to the addressed lanes
`default_nettype none

module store_align (
  input  mem_pkg::xlen_t     wdata_i,
  input  mem_pkg::lsu_size_t size_i,
  input  mem_pkg::byte_off_t off_i,
  output mem_pkg::xlen_t     data_o,
  output mem_pkg::strb_t     strb_o
);

  import mem_pkg::*;

  strb_t mask;

  always_comb begin
    case (size_i)
      SIZE_BYTE: mask = 8'h01;
      SIZE_HALF: mask = 8'h03;
      SIZE_WORD: mask = 8'h0f;
      default:   mask = 8'hff; // doubleword
    endcase
  end

  // offset in bytes, shift in bits
  assign data_o = wdata_i << {off_i, 3'b000};
  assign strb_o = mask << off_i;

endmodule

`default_nettype wire

//--- hw/load_extend.sv
// load extraction: picks the addressed bytes and zero or sign extends them
`default_nettype none

module load_extend (
  input  mem_pkg::xlen_t     word_i,
  input  mem_pkg::lsu_size_t size_i,
  input  mem_pkg::byte_off_t off_i,
  input  logic               sext_i,
  output mem_pkg::xlen_t     data_o
);

  import mem_pkg::*;

  xlen_t shifted;
  xlen_t keep;
  xlen_t fill;
  logic  sign;

  assign shifted = word_i >> {off_i, 3'b000};

  always_comb begin
    case (size_i)
      SIZE_BYTE: begin
        keep = 64'h0000_0000_0000_00ff;
        sign = shifted[7];
      end
      SIZE_HALF: begin
        keep = 64'h0000_0000_0000_ffff;
        sign = shifted[15];
      end
      SIZE_WORD: begin
        keep = 64'h0000_0000_ffff_ffff;
        sign = shifted[31];
      end
      default: begin
        keep = '1;
        sign = shifted[63];
      end
    endcase
  end

  assign fill   = {XLEN{sext_i & sign}}; // all zeros unless sign extending
  assign data_o = (shifted & keep) | (fill & ~keep);

endmodule

`default_nettype wire

//--- hw/lsu_ctrl.sv
// memory stage controller: takes one request, runs the bus handshakes, stalls the pipeline
`default_nettype none

module lsu_ctrl (
  input  logic               clk,
  input  logic               rst_n_i,
  input  mem_pkg::lsu_req_t  req_i,
  output logic               stall_o,
  output mem_pkg::xlen_t     rdata_o,
  output logic               wr_req_valid_o,
  output bus_pkg::wr_req_t   wr_req_o,
  input  logic               wr_req_ready_i,
  input  logic               wr_resp_valid_i,
  output logic               wr_resp_ready_o,
  output logic               rd_req_valid_o,
  output bus_pkg::rd_req_t   rd_req_o,
  input  logic               rd_req_ready_i,
  input  logic               rd_resp_valid_i,
  input  bus_pkg::rd_resp_t  rd_resp_i,
  output logic               rd_resp_ready_o
);

  import mem_pkg::*;

  typedef enum logic [2:0] {
    idle,
    wr_req,
    wr_resp,
    rd_req,
    rd_resp
  } state_t;

  state_t    state_q, state_d;
  lsu_req_t  req_q;
  byte_off_t off;
  xlen_t     st_data;
  strb_t     st_strb;
  xlen_t     ld_data;
  xlen_t     rdata_q;

  assign off = req_q.addr[2:0];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // latch the request only when we can take it
  always_ff @(posedge clk) begin
    if (state_q == idle && (req_i.rd_en || req_i.wr_en)) begin
      req_q <= req_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (req_i.wr_en) begin
          state_d = wr_req; // write wins if both strobes are up
        end else if (req_i.rd_en) begin
          state_d = rd_req;
        end
      end
      wr_req:  if (wr_req_ready_i)  state_d = wr_resp;
      wr_resp: if (wr_resp_valid_i) state_d = idle;
      rd_req:  if (rd_req_ready_i)  state_d = rd_resp;
      rd_resp: if (rd_resp_valid_i) state_d = idle;
      default: state_d = idle;
    endcase
  end

  assign stall_o         = (state_q != idle);
  assign wr_req_valid_o  = (state_q == wr_req);
  assign wr_resp_ready_o = (state_q == wr_resp);
  assign rd_req_valid_o  = (state_q == rd_req);
  assign rd_resp_ready_o = (state_q == rd_resp);

  store_align i_store_align (
    .wdata_i (req_q.wdata),
    .size_i  (req_q.size),
    .off_i   (off),
    .data_o  (st_data),
    .strb_o  (st_strb)
  );

  assign wr_req_o.addr = req_q.addr;
  assign wr_req_o.data = st_data;
  assign wr_req_o.strb = st_strb;

  assign rd_req_o.addr = req_q.addr;
  assign rd_req_o.size = req_q.size;

  load_extend i_load_extend (
    .word_i (rd_resp_i.data),
    .size_i (req_q.size),
    .off_i  (off),
    .sext_i (req_q.sext),
    .data_o (ld_data)
  );

  // result lands on the same edge that drops the stall
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (rd_resp_valid_i && rd_resp_ready_o) begin
      rdata_q <= ld_data;
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- hw/data_ram.sv
// data memory behind the valid/ready bus, byte strobed writes, programmable response delay
`default_nettype none

module data_ram #(
  parameter int RAM_WORDS  = 256,
  parameter int RESP_DELAY = 0
) (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               wr_req_valid_i,
  input  bus_pkg::wr_req_t   wr_req_i,
  output logic               wr_req_ready_o,
  output logic               wr_resp_valid_o,
  input  logic               wr_resp_ready_i,
  input  logic               rd_req_valid_i,
  input  bus_pkg::rd_req_t   rd_req_i,
  output logic               rd_req_ready_o,
  output logic               rd_resp_valid_o,
  output bus_pkg::rd_resp_t  rd_resp_o,
  input  logic               rd_resp_ready_i
);

  import mem_pkg::*;

  localparam int IDX_W = $clog2(RAM_WORDS);
  localparam int CNT_W = $clog2(RESP_DELAY + 2);

  typedef enum logic [1:0] {
    r_idle,
    r_req,
    r_resp
  } ram_state_t;

  xlen_t mem [RAM_WORDS];

  ram_state_t       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             is_wr_q;
  logic             wait_done;
  logic             wr_hs;
  logic             rd_hs;
  logic             resp_hs;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  xlen_t            rdata_q;

  assign wait_done = (cnt_q == '0);

  assign wr_req_ready_o  = (state_q == r_req)  && wait_done && is_wr_q;
  assign rd_req_ready_o  = (state_q == r_req)  && wait_done && !is_wr_q;
  assign wr_resp_valid_o = (state_q == r_resp) && wait_done && is_wr_q;
  assign rd_resp_valid_o = (state_q == r_resp) && wait_done && !is_wr_q;

  assign wr_hs   = wr_req_valid_i && wr_req_ready_o;
  assign rd_hs   = rd_req_valid_i && rd_req_ready_o;
  assign resp_hs = (wr_resp_valid_o && wr_resp_ready_i) ||
                   (rd_resp_valid_o && rd_resp_ready_i);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= r_idle;
      cnt_q   <= '0;
      is_wr_q <= 1'b0;
    end else begin
      case (state_q)
        r_idle: begin
          if (wr_req_valid_i || rd_req_valid_i) begin
            state_q <= r_req;
            cnt_q   <= CNT_W'(RESP_DELAY);
            is_wr_q <= wr_req_valid_i;
          end
        end
        r_req: begin
          if (!wait_done) begin
            cnt_q <= cnt_q - 1'b1;
          end else if (wr_hs || rd_hs) begin
            state_q <= r_resp;
            cnt_q   <= CNT_W'(RESP_DELAY); // space out the response too
          end
        end
        r_resp: begin
          if (!wait_done) begin
            cnt_q <= cnt_q - 1'b1;
          end else if (resp_hs) begin
            state_q <= r_idle;
          end
        end
        default: state_q <= r_idle;
      endcase
    end
  end

  // word index sits above the byte lane bits
  assign wr_idx = wr_req_i.addr[IDX_W+2:3];
  assign rd_idx = rd_req_i.addr[IDX_W+2:3];

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      for (int b = 0; b < 8; b++) begin
        if (wr_req_i.strb[b]) mem[wr_idx][b*8 +: 8] <= wr_req_i.data[b*8 +: 8];
      end
    end
    if (rd_hs) begin
      rdata_q <= mem[rd_idx]; // held until the response handshake
    end
  end

  assign rd_resp_o.data = rdata_q;

endmodule

`default_nettype wire

//--- hw/lsu_top.sv
// memory stage top: controller with its datapaths wired to the on-chip data memory
`default_nettype none

module lsu_top #(
  parameter int RAM_WORDS  = 256,
  parameter int RESP_DELAY = 0
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  mem_pkg::lsu_req_t req_i,
  output logic              stall_o,
  output mem_pkg::xlen_t    rdata_o
);

  import bus_pkg::*;

  logic     wr_req_valid;
  wr_req_t  wr_req;
  logic     wr_req_ready;
  logic     wr_resp_valid;
  logic     wr_resp_ready;
  logic     rd_req_valid;
  rd_req_t  rd_req;
  logic     rd_req_ready;
  logic     rd_resp_valid;
  rd_resp_t rd_resp;
  logic     rd_resp_ready;

  lsu_ctrl i_lsu_ctrl (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .req_i           (req_i),
    .stall_o         (stall_o),
    .rdata_o         (rdata_o),
    .wr_req_valid_o  (wr_req_valid),
    .wr_req_o        (wr_req),
    .wr_req_ready_i  (wr_req_ready),
    .wr_resp_valid_i (wr_resp_valid),
    .wr_resp_ready_o (wr_resp_ready),
    .rd_req_valid_o  (rd_req_valid),
    .rd_req_o        (rd_req),
    .rd_req_ready_i  (rd_req_ready),
    .rd_resp_valid_i (rd_resp_valid),
    .rd_resp_i       (rd_resp),
    .rd_resp_ready_o (rd_resp_ready)
  );

  data_ram #(
    .RAM_WORDS  (RAM_WORDS),
    .RESP_DELAY (RESP_DELAY)
  ) i_data_ram (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .wr_req_valid_i  (wr_req_valid),
    .wr_req_i        (wr_req),
    .wr_req_ready_o  (wr_req_ready),
    .wr_resp_valid_o (wr_resp_valid),
    .wr_resp_ready_i (wr_resp_ready),
    .rd_req_valid_i  (rd_req_valid),
    .rd_req_i        (rd_req),
    .rd_req_ready_o  (rd_req_ready),
    .rd_resp_valid_o (rd_resp_valid),
    .rd_resp_o       (rd_resp),
    .rd_resp_ready_i (rd_resp_ready)
  );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
// testbench clock source, free running with a fixed period
`default_nettype none

module tb_clock #(
  parameter int PERIOD = 40
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PERIOD / 2) clk_o = ~clk_o; // half period per phase

endmodule

`default_nettype wire

//--- bench/lsu_checker.sv
// result checker: compares load data with the expected value at each stall release
`default_nettype none

module lsu_checker (
  input  logic           clk,
  input  logic           rst_n_i,
  input  logic           stall_i,
  input  mem_pkg::xlen_t rdata_i,
  input  logic           exp_load_i,
  input  mem_pkg::xlen_t exp_value_i,
  input  logic [63:0]    exp_name_i,
  output int             err_count_o,
  output int             fall_count_o
);

  import mem_pkg::*;

  logic        stall_q;
  logic        load_q;
  xlen_t       value_q;
  logic [63:0] name_q;

  // falling edge sampling, outputs are settled here
  always @(negedge clk) begin
    if (!rst_n_i) begin
      stall_q      <= 1'b0;
      load_q       <= 1'b0;
      err_count_o  <= 0;
      fall_count_o <= 0;
    end else begin
      if (stall_i && !stall_q) begin // request taken, keep what it should return
        load_q  <= exp_load_i;
        value_q <= exp_value_i;
        name_q  <= exp_name_i;
      end
      if (!stall_i && stall_q) begin
        fall_count_o <= fall_count_o + 1;
        if (load_q && rdata_i !== value_q) begin
          err_count_o <= err_count_o + 1;
          $display("CHECK FAILED %0s: expected %h, actual %h", name_q, value_q, rdata_i);
        end
      end
      stall_q <= stall_i;
    end
  end

endmodule

`default_nettype wire

//--- bench/lsu_assertions.sv
// bus handshake and stall assertions for the memory stage controller
`default_nettype none

module lsu_assertions (
  input logic             clk,
  input logic             rst_n_i,
  input logic             stall_i,
  input logic             wr_req_valid_i,
  input bus_pkg::wr_req_t wr_req_i,
  input logic             wr_req_ready_i,
  input logic             wr_resp_valid_i,
  input logic             wr_resp_ready_i,
  input logic             rd_req_valid_i,
  input bus_pkg::rd_req_t rd_req_i,
  input logic             rd_req_ready_i,
  input logic             rd_resp_valid_i,
  input logic             rd_resp_ready_i
);

  logic wr_busy;
  logic rd_busy;

  // any handshake signal of a path, from either side
  assign wr_busy = wr_req_valid_i || wr_req_ready_i || wr_resp_valid_i || wr_resp_ready_i;
  assign rd_busy = rd_req_valid_i || rd_req_ready_i || rd_resp_valid_i || rd_resp_ready_i;

  a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    wr_req_valid_i && !wr_req_ready_i |=> wr_req_valid_i && $stable(wr_req_i))
    else $error("write request dropped or changed before ready");

  a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    rd_req_valid_i && !rd_req_ready_i |=> rd_req_valid_i && $stable(rd_req_i))
    else $error("read request dropped or changed before ready");

  a_one_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(wr_busy && rd_busy))
    else $error("read and write path active together");

  a_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
    wr_req_valid_i || rd_req_valid_i || wr_resp_valid_i || rd_resp_valid_i |-> stall_i)
    else $error("request or response valid high without stall");

  // everything quiet in the cycle after a reset edge
  a_reset: assert property (@(posedge clk)
    !rst_n_i |=> !stall_i && !wr_req_valid_i && !rd_req_valid_i && !wr_req_ready_i &&
                 !rd_req_ready_i && !wr_resp_ready_i && !rd_resp_ready_i &&
                 !wr_resp_valid_i && !rd_resp_valid_i)
    else $error("stall, valid or ready high after reset");

endmodule

bind lsu_ctrl lsu_assertions i_lsu_assertions (
  .clk             (clk),
  .rst_n_i         (rst_n_i),
  .stall_i         (stall_o),
  .wr_req_valid_i  (wr_req_valid_o),
  .wr_req_i        (wr_req_o),
  .wr_req_ready_i  (wr_req_ready_i),
  .wr_resp_valid_i (wr_resp_valid_i),
  .wr_resp_ready_i (wr_resp_ready_o),
  .rd_req_valid_i  (rd_req_valid_o),
  .rd_req_i        (rd_req_o),
  .rd_req_ready_i  (rd_req_ready_i),
  .rd_resp_valid_i (rd_resp_valid_i),
  .rd_resp_ready_i (rd_resp_ready_o)
);

`default_nettype wire

//--- bench/lsu_tb.sv
// testbench top for the memory stage: table driven loads and stores against the data memory
`default_nettype none

module lsu_tb;

  import mem_pkg::*;

  localparam int N_OPS = 21;

  typedef enum logic [1:0] {
    op_st,
    op_ld,
    op_st_pulse // store with a stray read strobe while stalled
  } op_t;

  typedef struct packed {
    logic [63:0] name;
    op_t         op;
    addr_t       addr;
    lsu_size_t   size;
    logic        sext;
    xlen_t       wdata;
    xlen_t       value; // expected load result
  } op_entry_t;

  logic        clk;
  logic        rst_n;
  lsu_req_t    req;
  logic        stall;
  xlen_t       rdata;
  logic        exp_load;
  xlen_t       exp_value;
  logic [63:0] exp_name;
  int          chk_errors;
  int          falls;
  int          other_errors;
  int          n_filled;
  int          seed;
  int          gap;
  op_entry_t   ops [N_OPS];

  tb_clock #(.PERIOD(40)) i_clock (.clk_o(clk));

  lsu_top #(
    .RAM_WORDS  (64),
    .RESP_DELAY (3)
  ) i_dut (
    .clk     (clk),
    .rst_n_i (rst_n),
    .req_i   (req),
    .stall_o (stall),
    .rdata_o (rdata)
  );

  lsu_checker i_checker (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .stall_i      (stall),
    .rdata_i      (rdata),
    .exp_load_i   (exp_load),
    .exp_value_i  (exp_value),
    .exp_name_i   (exp_name),
    .err_count_o  (chk_errors),
    .fall_count_o (falls)
  );

  task automatic add_op(input logic [63:0] name, input op_t op, input addr_t addr,
                        input lsu_size_t size, input logic sext, input xlen_t wdata,
                        input xlen_t value);
    ops[n_filled] = '{name, op, addr, size, sext, wdata, value};
    n_filled++;
  endtask

  // one-cycle strobe, then wait for the stage to let go
  task automatic run_op(input op_entry_t e);
    req.addr  = e.addr;
    req.size  = e.size;
    req.sext  = e.sext;
    req.wdata = e.wdata;
    req.wr_en = (e.op != op_ld);
    req.rd_en = (e.op == op_ld);
    exp_load  = (e.op == op_ld);
    exp_value = e.value;
    exp_name  = e.name;
    @(negedge clk);
    req.wr_en = 1'b0;
    req.rd_en = 1'b0;
    if (e.op == op_st_pulse) begin
      @(negedge clk);
      if (!stall) begin
        other_errors++;
        $display("ERROR: %0s was not stalled when the stray read strobe went out", e.name);
      end
      req.addr  = 64'h100;
      req.rd_en = 1'b1;
      @(negedge clk);
      req.rd_en = 1'b0;
    end
    while (stall) @(negedge clk);
  endtask

  initial begin
    seed         = 32'h5b6a_cf40;
    n_filled     = 0;
    other_errors = 0;
    rst_n        = 1'b0;
    req          = '0;
    exp_load     = 1'b0;
    exp_value    = '0;
    exp_name     = '0;

    add_op("sd_a",    op_st, 64'h100, 2'd3, 1'b0, 64'h0123_4567_89ab_cdef, 64'h0);
    add_op("ld_a",    op_ld, 64'h100, 2'd3, 1'b0, 64'h0, 64'h0123_4567_89ab_cdef);
    add_op("sd_b",    op_st, 64'h108, 2'd3, 1'b0, 64'h1122_3344_5566_7788, 64'h0);
    add_op("sw_b0",   op_st, 64'h108, 2'd2, 1'b0, 64'hffff_ffff_cafe_f00d, 64'h0);
    add_op("sb_b5",   op_st, 64'h10d, 2'd0, 1'b0, 64'hdead_beef_0000_005a, 64'h0);
    add_op("sh_b6",   op_st, 64'h10e, 2'd1, 1'b0, 64'h1234_5678_9abc_beef, 64'h0);
    add_op("ld_b",    op_ld, 64'h108, 2'd3, 1'b0, 64'h0, 64'hbeef_5a44_cafe_f00d);
    add_op("lb_b1",   op_ld, 64'h109, 2'd0, 1'b1, 64'h0, 64'hffff_ffff_ffff_fff0);
    add_op("lbu_b1",  op_ld, 64'h109, 2'd0, 1'b0, 64'h0, 64'h0000_0000_0000_00f0);
    add_op("lb_b5",   op_ld, 64'h10d, 2'd0, 1'b1, 64'h0, 64'h0000_0000_0000_005a);
    add_op("lh_b6",   op_ld, 64'h10e, 2'd1, 1'b1, 64'h0, 64'hffff_ffff_ffff_beef);
    add_op("lhu_b6",  op_ld, 64'h10e, 2'd1, 1'b0, 64'h0, 64'h0000_0000_0000_beef);
    add_op("lh_b2",   op_ld, 64'h10a, 2'd1, 1'b1, 64'h0, 64'hffff_ffff_ffff_cafe);
    add_op("lw_b0",   op_ld, 64'h108, 2'd2, 1'b1, 64'h0, 64'hffff_ffff_cafe_f00d);
    add_op("lwu_b4",  op_ld, 64'h10c, 2'd2, 1'b0, 64'h0, 64'h0000_0000_beef_5a44);
    add_op("lw_b4",   op_ld, 64'h10c, 2'd2, 1'b1, 64'h0, 64'hffff_ffff_beef_5a44);
    add_op("lbu_a0",  op_ld, 64'h100, 2'd0, 1'b0, 64'h0, 64'h0000_0000_0000_00ef);
    add_op("lb_a0",   op_ld, 64'h100, 2'd0, 1'b1, 64'h0, 64'hffff_ffff_ffff_ffef);
    add_op("lw_a4",   op_ld, 64'h104, 2'd2, 1'b1, 64'h0, 64'h0000_0000_0123_4567);
    add_op("sd_poke", op_st_pulse, 64'h110, 2'd3, 1'b0, 64'h0f0e_0d0c_0b0a_0908, 64'h0);
    add_op("ld_c",    op_ld, 64'h110, 2'd3, 1'b1, 64'h0, 64'h0f0e_0d0c_0b0a_0908);

    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    for (int i = 0; i < N_OPS; i++) begin
      run_op(ops[i]);
      gap = $random(seed) & 3;
      repeat (gap) @(negedge clk);
    end

    repeat (2) @(negedge clk);
    if (falls != N_OPS) begin
      other_errors++;
      $display("ERROR: stall fell %0d times for %0d operations", falls, N_OPS);
    end
    $display("errors: %0d data mismatches, %0d other", chk_errors, other_errors);
    if (chk_errors == 0 && other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // 40 cycles per table entry is far above the worst case with delay 3
  initial begin
    repeat (N_OPS * 40) @(posedge clk);
    $display("ERROR: memory stage never released its stall, run stopped");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
hw/mem_pkg.sv
hw/bus_pkg.sv
hw/store_align.sv
hw/load_extend.sv
hw/lsu_ctrl.sv
hw/data_ram.sv
hw/lsu_top.sv
bench/tb_clock.sv
bench/lsu_checker.sv
bench/lsu_assertions.sv
bench/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu_stage

sources:
  - hw/mem_pkg.sv
  - hw/bus_pkg.sv
  - hw/store_align.sv
  - hw/load_extend.sv
  - hw/lsu_ctrl.sv
  - hw/data_ram.sv
  - hw/lsu_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/lsu_checker.sv
      - bench/lsu_assertions.sv
      - bench/lsu_tb.sv
